// File: bench/core_top_chk.sv
`timescale 1ns/1ns

module core_top_chk (
	input logic clk_i,
	input logic reset_i,
	input logic wb_valid_i,
	input logic store_valid_i,
	input logic illegal_i,
	input logic [core_cfg_pkg::STRB_W-1:0] store_strb_i
);

	// a retiring instruction drives only one of the three strobes
	one_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
		$onehot0({wb_valid_i, store_valid_i, illegal_i}))
		else $error("more than one output strobe in a cycle");

	// every store size covers at least one byte lane
	store_has_bytes: assert property (@(posedge clk_i) disable iff (reset_i)
		store_valid_i |-> store_strb_i != '0)
		else $error("store issued with an empty byte mask");

endmodule

bind core_top core_top_chk core_top_chk_inst (
	.clk_i(clk_i),
	.reset_i(reset_i),
	.wb_valid_i(wb_valid_o),
	.store_valid_i(store_valid_o),
	.illegal_i(illegal_o),
	.store_strb_i(store_strb_o)
);

// File: bench/core_top_tb.sv
`timescale 1ns/1ns

module core_top_tb;
	localparam int XLEN = core_cfg_pkg::XLEN;
	localparam int AW = core_cfg_pkg::REG_ADDR_W;
	localparam int SW = core_cfg_pkg::STRB_W;
	localparam int CW = core_cfg_pkg::CNT_W;
	localparam int NUM_INST = 400;
	localparam int ISSUE_LIMIT = 4000;
	localparam int DRAIN_LIMIT = 50;

	// kind 0 is writeback, 1 is store, 2 is illegal
	typedef struct packed {
		logic [1:0] kind;
		logic [31:0] due;
		logic [AW-1:0] rd;
		logic [XLEN-1:0] data;
		logic [XLEN-1:0] sdata;
		logic [SW-1:0] strb;
	} expect_t;

	logic clk_i;
	logic reset_i;
	logic [core_cfg_pkg::INST_W-1:0] inst_i;
	logic inst_valid_i;
	logic wb_valid_o;
	logic [AW-1:0] wb_rd_o;
	logic [XLEN-1:0] wb_data_o;
	logic store_valid_o;
	logic [XLEN-1:0] store_addr_o;
	logic [XLEN-1:0] store_data_o;
	logic [SW-1:0] store_strb_o;
	logic illegal_o;
	logic [CW-1:0] alu_count_o;
	logic [CW-1:0] store_count_o;
	logic [CW-1:0] illegal_count_o;

	logic [XLEN-1:0] model_regs [32];
	expect_t exp_q [$];
	logic [31:0] rng_state;
	int edge_cnt = 0;
	int exp_alu;
	int exp_store;
	int exp_ill;
	int mismatch_cnt;
	int other_cnt;

	core_top core_top_inst (
		.clk_i(clk_i), .reset_i(reset_i), .inst_i(inst_i), .inst_valid_i(inst_valid_i),
		.wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
		.store_valid_o(store_valid_o), .store_addr_o(store_addr_o),
		.store_data_o(store_data_o), .store_strb_o(store_strb_o), .illegal_o(illegal_o),
		.alu_count_o(alu_count_o), .store_count_o(store_count_o),
		.illegal_count_o(illegal_count_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		edge_cnt <= edge_cnt + 1;
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic check_rd_index(input string name, input logic [AW-1:0] got,
		input logic [AW-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic compare_word(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic verify_byte_mask(input string name, input logic [SW-1:0] got,
		input logic [SW-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic match_counter(input string name, input logic [CW-1:0] got,
		input logic [CW-1:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_strobes(input logic wb, input logic st, input logic il);
		if (wb_valid_o !== wb || store_valid_o !== st || illegal_o !== il) begin
			$display("wrong output strobes at edge %0d: wb %b store %b illegal %b",
				edge_cnt, wb_valid_o, store_valid_o, illegal_o);
			other_cnt++;
		end
	endtask

	// builds one word through the union and runs it on the model in issue order
	task automatic make_instruction(input logic [31:0] due, input logic [AW-1:0] init_rd,
		output logic [31:0] word);
		logic [31:0] r;
		logic [31:0] r2;
		logic [3:0] sel;
		logic [2:0] f3;
		logic [11:0] imm;
		logic [AW-1:0] rs1;
		logic [AW-1:0] rs2;
		logic [AW-1:0] rd;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] src;
		logic [XLEN-1:0] res;
		logic [2:0] lane;
		int nbytes;
		rv_isa_pkg::rv_inst_u w;
		expect_t e;
		r = lcg_next();
		r2 = lcg_next();
		sel = r[31:28];
		rs1 = {2'b00, r[2:0]};
		rs2 = {2'b00, r[5:3]};
		rd = {2'b00, r[8:6]};
		f3 = r[11:9];
		imm = r2[31:20];
		// first writes give x1..x7 a known value
		if (init_rd != '0) begin
			sel = 4'd0;
			f3 = rv_isa_pkg::F3_ADD;
			rs1 = '0;
			rd = init_rd;
		end
		e = '0;
		e.due = due;
		w = '0;
		if (sel < 4'd10) begin
			if (f3 == rv_isa_pkg::F3_SLL) begin
				imm = {6'b000000, r2[5:0]};
			end else if (f3 == rv_isa_pkg::F3_SR) begin
				// bit 10 picks SRAI
				imm = {1'b0, r2[6], 4'b0000, r2[5:0]};
			end
			a = model_regs[rs1];
			b = {{(XLEN-12){imm[11]}}, imm};
			case (f3)
				rv_isa_pkg::F3_ADD: res = a + b;
				rv_isa_pkg::F3_SLL: res = a << imm[5:0];
				rv_isa_pkg::F3_SLT: res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
				rv_isa_pkg::F3_SLTU: res = {{(XLEN-1){1'b0}}, a < b};
				rv_isa_pkg::F3_XOR: res = a ^ b;
				rv_isa_pkg::F3_SR: res = imm[10] ? $unsigned($signed(a) >>> imm[5:0]) :
					a >> imm[5:0];
				rv_isa_pkg::F3_OR: res = a | b;
				default: res = a & b;
			endcase
			w.i_view.imm = imm;
			w.i_view.rs1 = rs1;
			w.i_view.funct3 = f3;
			w.i_view.rd = rd;
			w.i_view.opcode = rv_isa_pkg::OPC_OP_IMM;
			e.kind = 2'd0;
			e.rd = rd;
			e.data = res;
			if (rd != '0) begin
				model_regs[rd] = res;
			end
			exp_alu++;
		end else if (sel < 4'd13) begin
			a = model_regs[rs1];
			b = {{(XLEN-12){imm[11]}}, imm};
			src = model_regs[rs2];
			e.data = a + b;
			lane = e.data[2:0];
			// SB, SH, SW and SD cover 1, 2, 4 and 8 bytes
			nbytes = 1 << f3[1:0];
			e.kind = 2'd1;
			// byte i of the bus carries source byte i - lane
			for (int i = 0; i < SW; i++) begin
				if (i >= lane) begin
					e.sdata[8*i +: 8] = src[8*(i-lane) +: 8];
				end
				if (i >= lane && i < lane + nbytes) begin
					e.strb[i] = 1'b1;
				end
			end
			w.s_view.imm_hi = imm[11:5];
			w.s_view.rs2 = rs2;
			w.s_view.rs1 = rs1;
			w.s_view.funct3 = {1'b0, f3[1:0]};
			w.s_view.imm_lo = imm[4:0];
			w.s_view.opcode = rv_isa_pkg::OPC_STORE;
			exp_store++;
		end else begin
			w = r2;
			if (r[12]) begin
				// store opcode with no size encoding
				w.s_view.opcode = rv_isa_pkg::OPC_STORE;
				w.s_view.funct3[2] = 1'b1;
			end else if (w.i_view.opcode == rv_isa_pkg::OPC_OP_IMM ||
				w.i_view.opcode == rv_isa_pkg::OPC_STORE) begin
				w.i_view.opcode = 7'b0110011;
			end
			e.kind = 2'd2;
			exp_ill++;
		end
		exp_q.push_back(e);
		word = w;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk_i) begin : check_outputs
		expect_t e;
		if (!reset_i) begin
			if (exp_q.size() > 0 && exp_q[0].due == edge_cnt) begin
				e = exp_q.pop_front();
				if (e.kind == 2'd0) begin
					check_strobes(1'b1, 1'b0, 1'b0);
					check_rd_index("wb_rd_o", wb_rd_o, e.rd);
					compare_word("wb_data_o", wb_data_o, e.data);
				end else if (e.kind == 2'd1) begin
					check_strobes(1'b0, 1'b1, 1'b0);
					compare_word("store_addr_o", store_addr_o, e.data);
					compare_word("store_data_o", store_data_o, e.sdata);
					verify_byte_mask("store_strb_o", store_strb_o, e.strb);
				end else begin
					check_strobes(1'b0, 1'b0, 1'b1);
				end
			end else begin
				check_strobes(1'b0, 1'b0, 1'b0);
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] word;
		logic [AW-1:0] init_rd;
		int n;
		int cyc;
		int wait_cnt;
		rng_state = 32'hb1696df4;
		clk_i = 1'b0;
		reset_i = 1'b1;
		inst_i = rv_isa_pkg::INST_NOP;
		inst_valid_i = 1'b0;
		exp_alu = 0;
		exp_store = 0;
		exp_ill = 0;
		mismatch_cnt = 0;
		other_cnt = 0;
		for (int i = 0; i < 32; i++) begin
			model_regs[i] = '0;
		end
		repeat (10) @(posedge clk_i);
		reset_i <= 1'b0;
		@(negedge clk_i);
		match_counter("alu_count_o", alu_count_o, '0);
		match_counter("store_count_o", store_count_o, '0);
		match_counter("illegal_count_o", illegal_count_o, '0);

		n = 0;
		for (cyc = 0; n < NUM_INST && cyc < ISSUE_LIMIT; cyc++) begin
			@(posedge clk_i);
			r = lcg_next();
			if (n < 7 || r[31:30] != 2'b00) begin
				init_rd = (n < 7) ? AW'(n + 1) : '0;
				// count still lags one edge here and the word is sampled at the next edge
				make_instruction(edge_cnt + 4, init_rd, word);
				inst_i <= word;
				inst_valid_i <= 1'b1;
				n++;
			end else begin
				inst_i <= lcg_next();
				inst_valid_i <= 1'b0;
			end
		end
		if (n < NUM_INST) begin
			$display("stimulus stopped after %0d of %0d instructions", n, NUM_INST);
			other_cnt++;
		end
		@(posedge clk_i);
		inst_valid_i <= 1'b0;

		wait_cnt = 0;
		while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
			@(posedge clk_i);
			wait_cnt++;
		end
		if (exp_q.size() > 0) begin
			$display("timeout: %0d results never came out of the pipeline", exp_q.size());
			other_cnt++;
		end else begin
			@(negedge clk_i);
			match_counter("alu_count_o", alu_count_o, CW'(exp_alu));
			match_counter("store_count_o", store_count_o, CW'(exp_store));
			match_counter("illegal_count_o", illegal_count_o, CW'(exp_ill));
		end
		$display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: project.f
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/decode.sv
source/xrs_file.sv
source/int_alu.sv
source/store_unit.sv
source/retire_counter.sv
source/core_top.sv
bench/core_top_chk.sv
bench/core_top_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module core_top_tb -f project.f \
	> build.log 2>&1 \
	&& ./obj_dir/Vcore_top_tb > sim.log 2>&1 \
	|| { cat build.log; echo "Regression failed" >> sim.log; }
cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: source/core_cfg_pkg.sv
package core_cfg_pkg;

	// integer datapath width
	localparam int XLEN = 64;

	// register index and instruction widths
	localparam int REG_ADDR_W = 5;
	localparam int INST_W = 32;

	// retirement statistics
	localparam int CNT_W = 16;

	// one mask bit per byte lane of the store bus
	localparam int STRB_W = XLEN / 8;

endpackage

// File: source/core_top.sv
`timescale 1ns/1ns

module core_top (
	input  logic clk_i,
	input  logic reset_i,
	input  logic [core_cfg_pkg::INST_W-1:0] inst_i,
	input  logic inst_valid_i,
	output logic wb_valid_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [core_cfg_pkg::XLEN-1:0] wb_data_o,
	output logic store_valid_o,
	output logic [core_cfg_pkg::XLEN-1:0] store_addr_o,
	output logic [core_cfg_pkg::XLEN-1:0] store_data_o,
	output logic [core_cfg_pkg::STRB_W-1:0] store_strb_o,
	output logic illegal_o,
	output logic [core_cfg_pkg::CNT_W-1:0] alu_count_o,
	output logic [core_cfg_pkg::CNT_W-1:0] store_count_o,
	output logic [core_cfg_pkg::CNT_W-1:0] illegal_count_o
);
	localparam int XLEN = core_cfg_pkg::XLEN;
	localparam int AW = core_cfg_pkg::REG_ADDR_W;

	logic [AW-1:0] rs1, rs2, id_rd, ex_rd;
	logic [XLEN-1:0] rs1val, rs2val, inpa, inpb, id_dat, ex_q, ex_dat;
	logic invb, cflag, lsh_en, rsh_en, ltu_en, lts_en, sum_en, and_en, xor_en;
	logic id_we, id_mem, id_illegal, id_valid;
	logic ex_valid, ex_wb, ex_store, ex_illegal;
	logic [2:0] id_rwe, ex_rwe;

	decode decode_inst (
		.clk_i(clk_i), .reset_i(reset_i), .inst_i(inst_i), .inst_en_i(inst_valid_i),
		.rs1val_i(rs1val), .rs2val_i(rs2val), .ex_rd_i(ex_rd), .mem_rd_i(wb_rd_o),
		.ex_q_i(ex_q), .mem_q_i(wb_data_o), .inpa_o(inpa), .inpb_o(inpb),
		.dat_o(id_dat), .invb_o(invb), .cflag_o(cflag), .lsh_en_o(lsh_en),
		.rsh_en_o(rsh_en), .ltu_en_o(ltu_en), .lts_en_o(lts_en), .sum_en_o(sum_en),
		.and_en_o(and_en), .xor_en_o(xor_en), .rd_o(id_rd), .rs1_o(rs1), .rs2_o(rs2),
		.we_o(id_we), .mem_o(id_mem), .xrs_rwe_o(id_rwe), .illegal_o(id_illegal),
		.valid_o(id_valid)
	);

	xrs_file xrs_file_inst (
		.clk_i(clk_i), .rs1_i(rs1), .rs2_i(rs2), .we_i(wb_valid_o), .rd_i(wb_rd_o),
		.wdata_i(wb_data_o), .rs1val_o(rs1val), .rs2val_o(rs2val)
	);

	int_alu int_alu_inst (
		.clk_i(clk_i), .reset_i(reset_i), .valid_i(id_valid), .inpa_i(inpa),
		.inpb_i(inpb), .invb_i(invb), .cflag_i(cflag), .lsh_en_i(lsh_en),
		.rsh_en_i(rsh_en), .ltu_en_i(ltu_en), .lts_en_i(lts_en), .sum_en_i(sum_en),
		.and_en_i(and_en), .xor_en_i(xor_en), .rd_i(id_rd), .we_i(id_we),
		.mem_i(id_mem), .dat_i(id_dat), .xrs_rwe_i(id_rwe), .illegal_i(id_illegal),
		.valid_o(ex_valid), .q_o(ex_q), .rd_o(ex_rd), .wb_o(ex_wb), .store_o(ex_store),
		.dat_o(ex_dat), .xrs_rwe_o(ex_rwe), .illegal_o(ex_illegal)
	);

	store_unit store_unit_inst (
		.clk_i(clk_i), .reset_i(reset_i), .valid_i(ex_valid), .q_i(ex_q),
		.rd_i(ex_rd), .wb_i(ex_wb), .store_i(ex_store), .dat_i(ex_dat),
		.xrs_rwe_i(ex_rwe), .illegal_i(ex_illegal), .wb_valid_o(wb_valid_o),
		.wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o), .store_valid_o(store_valid_o),
		.store_addr_o(store_addr_o), .store_data_o(store_data_o),
		.store_strb_o(store_strb_o), .illegal_o(illegal_o)
	);

	retire_counter retire_counter_inst (
		.clk_i(clk_i), .reset_i(reset_i), .wb_valid_i(wb_valid_o),
		.store_valid_i(store_valid_o), .illegal_i(illegal_o),
		.alu_count_o(alu_count_o), .store_count_o(store_count_o),
		.illegal_count_o(illegal_count_o)
	);

endmodule

// File: source/decode.sv
`timescale 1ns/1ns

module decode (
	input  logic clk_i,
	input  logic reset_i,
	input  logic [core_cfg_pkg::INST_W-1:0] inst_i,
	input  logic inst_en_i,
	input  logic [core_cfg_pkg::XLEN-1:0] rs1val_i,
	input  logic [core_cfg_pkg::XLEN-1:0] rs2val_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] ex_rd_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] mem_rd_i,
	input  logic [core_cfg_pkg::XLEN-1:0] ex_q_i,
	input  logic [core_cfg_pkg::XLEN-1:0] mem_q_i,
	output logic [core_cfg_pkg::XLEN-1:0] inpa_o,
	output logic [core_cfg_pkg::XLEN-1:0] inpb_o,
	output logic [core_cfg_pkg::XLEN-1:0] dat_o,
	output logic invb_o,
	output logic cflag_o,
	output logic lsh_en_o,
	output logic rsh_en_o,
	output logic ltu_en_o,
	output logic lts_en_o,
	output logic sum_en_o,
	output logic and_en_o,
	output logic xor_en_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2_o,
	output logic we_o,
	output logic mem_o,
	output logic [2:0] xrs_rwe_o,
	output logic illegal_o,
	output logic valid_o
);
	localparam int XLEN = core_cfg_pkg::XLEN;

	rv_isa_pkg::rv_inst_u inst_in;
	rv_isa_pkg::rv_inst_u inst_r;
	logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1_r;
	logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2_r;
	logic [XLEN-1:0] rs1_fwd;
	logic [XLEN-1:0] rs2_fwd;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_s;

	// register file is read a cycle early, straight from the incoming word
	assign inst_in = inst_i;
	assign rs1_o = inst_in.i_view.rs1;
	assign rs2_o = inst_in.s_view.rs2;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			inst_r <= rv_isa_pkg::INST_NOP;
			valid_o <= 1'b0;
		end else begin
			valid_o <= inst_en_i;
			if (inst_en_i) begin
				inst_r <= inst_i;
			end
		end
	end

	assign rs1_r = inst_r.i_view.rs1;
	assign rs2_r = inst_r.s_view.rs2;
	assign rd_o = inst_r.i_view.rd;

	// youngest producer wins, x0 never forwards
	assign rs1_fwd = (rs1_r != '0 && ex_rd_i == rs1_r) ? ex_q_i :
		(rs1_r != '0 && mem_rd_i == rs1_r) ? mem_q_i : rs1val_i;
	assign rs2_fwd = (rs2_r != '0 && ex_rd_i == rs2_r) ? ex_q_i :
		(rs2_r != '0 && mem_rd_i == rs2_r) ? mem_q_i : rs2val_i;

	assign imm_i = {{(XLEN-12){inst_r.i_view.imm[11]}}, inst_r.i_view.imm};
	assign imm_s = {{(XLEN-12){inst_r.s_view.imm_hi[6]}}, inst_r.s_view.imm_hi,
		inst_r.s_view.imm_lo};

	always_comb begin
		illegal_o = 1'b1;
		inpa_o = '0;
		inpb_o = '0;
		dat_o = '0;
		invb_o = 1'b0;
		cflag_o = 1'b0;
		lsh_en_o = 1'b0;
		rsh_en_o = 1'b0;
		ltu_en_o = 1'b0;
		lts_en_o = 1'b0;
		sum_en_o = 1'b0;
		and_en_o = 1'b0;
		xor_en_o = 1'b0;
		we_o = 1'b0;
		mem_o = 1'b0;
		xrs_rwe_o = rv_isa_pkg::XRS_RWE_S64;
		case (inst_r.i_view.opcode)
			rv_isa_pkg::OPC_STORE: begin
				// funct3[2] set has no store encoding
				if (!inst_r.s_view.funct3[2]) begin
					illegal_o = 1'b0;
					inpa_o = rs1_fwd;
					inpb_o = imm_s;
					sum_en_o = 1'b1;
					mem_o = 1'b1;
					dat_o = rs2_fwd;
					case (inst_r.s_view.funct3[1:0])
						2'b00: xrs_rwe_o = rv_isa_pkg::XRS_RWE_S8;
						2'b01: xrs_rwe_o = rv_isa_pkg::XRS_RWE_S16;
						2'b10: xrs_rwe_o = rv_isa_pkg::XRS_RWE_S32;
						default: xrs_rwe_o = rv_isa_pkg::XRS_RWE_S64;
					endcase
				end
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				illegal_o = 1'b0;
				inpa_o = rs1_fwd;
				inpb_o = imm_i;
				we_o = 1'b1;
				case (inst_r.i_view.funct3)
					rv_isa_pkg::F3_ADD: sum_en_o = 1'b1;
					rv_isa_pkg::F3_SLL: lsh_en_o = 1'b1;
					// compares run through the adder as a - b
					rv_isa_pkg::F3_SLT: begin
						lts_en_o = 1'b1;
						invb_o = 1'b1;
					end
					rv_isa_pkg::F3_SLTU: begin
						ltu_en_o = 1'b1;
						invb_o = 1'b1;
					end
					rv_isa_pkg::F3_XOR: xor_en_o = 1'b1;
					rv_isa_pkg::F3_SR: begin
						rsh_en_o = 1'b1;
						// imm bit 10 selects SRAI
						cflag_o = inst_r.i_view.imm[10];
					end
					rv_isa_pkg::F3_OR: begin
						and_en_o = 1'b1;
						xor_en_o = 1'b1;
					end
					default: and_en_o = 1'b1;
				endcase
			end
			default: begin
				illegal_o = 1'b1;
			end
		endcase
	end

endmodule

// File: source/int_alu.sv
`timescale 1ns/1ns

module int_alu (
	input  logic clk_i,
	input  logic reset_i,
	input  logic valid_i,
	input  logic [core_cfg_pkg::XLEN-1:0] inpa_i,
	input  logic [core_cfg_pkg::XLEN-1:0] inpb_i,
	input  logic invb_i,
	input  logic cflag_i,
	input  logic lsh_en_i,
	input  logic rsh_en_i,
	input  logic ltu_en_i,
	input  logic lts_en_i,
	input  logic sum_en_i,
	input  logic and_en_i,
	input  logic xor_en_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic we_i,
	input  logic mem_i,
	input  logic [core_cfg_pkg::XLEN-1:0] dat_i,
	input  logic [2:0] xrs_rwe_i,
	input  logic illegal_i,
	output logic valid_o,
	output logic [core_cfg_pkg::XLEN-1:0] q_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_o,
	output logic wb_o,
	output logic store_o,
	output logic [core_cfg_pkg::XLEN-1:0] dat_o,
	output logic [2:0] xrs_rwe_o,
	output logic illegal_o
);
	localparam int XLEN = core_cfg_pkg::XLEN;

	logic [XLEN-1:0] b_op;
	logic [XLEN:0] sum;
	logic [5:0] shamt;
	logic [XLEN-1:0] lsh;
	logic [XLEN-1:0] rsh;
	logic ltu;
	logic lts;
	logic [XLEN-1:0] q;
	logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_r;

	// invb turns the adder into a - b for the compares
	assign b_op = inpb_i ^ {XLEN{invb_i}};
	assign sum = {1'b0, inpa_i} + {1'b0, b_op} + {{XLEN{1'b0}}, invb_i};

	assign shamt = inpb_i[5:0];
	assign lsh = inpa_i << shamt;
	assign rsh = cflag_i ? $unsigned($signed(inpa_i) >>> shamt) : (inpa_i >> shamt);

	// no carry out of a - b means a borrow
	assign ltu = ~sum[XLEN];
	assign lts = (inpa_i[XLEN-1] ^ inpb_i[XLEN-1]) ? inpa_i[XLEN-1] : sum[XLEN-1];

	// AND and XOR together give OR
	assign q = ({XLEN{sum_en_i}} & sum[XLEN-1:0]) |
		({XLEN{lsh_en_i}} & lsh) |
		({XLEN{rsh_en_i}} & rsh) |
		({XLEN{ltu_en_i}} & {{(XLEN-1){1'b0}}, ltu}) |
		({XLEN{lts_en_i}} & {{(XLEN-1){1'b0}}, lts}) |
		({XLEN{and_en_i}} & (inpa_i & inpb_i)) |
		({XLEN{xor_en_i}} & (inpa_i ^ inpb_i));

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			valid_o <= 1'b0;
			wb_o <= 1'b0;
			store_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
			wb_o <= valid_i & we_i;
			store_o <= valid_i & mem_i;
			illegal_o <= valid_i & illegal_i;
		end
		q_o <= q;
		rd_r <= rd_i;
		dat_o <= dat_i;
		xrs_rwe_o <= xrs_rwe_i;
	end

	// forwarding tag is zero when nothing is written back
	assign rd_o = wb_o ? rd_r : '0;

endmodule

// File: source/retire_counter.sv
`timescale 1ns/1ns

module retire_counter (
	input  logic clk_i,
	input  logic reset_i,
	input  logic wb_valid_i,
	input  logic store_valid_i,
	input  logic illegal_i,
	output logic [core_cfg_pkg::CNT_W-1:0] alu_count_o,
	output logic [core_cfg_pkg::CNT_W-1:0] store_count_o,
	output logic [core_cfg_pkg::CNT_W-1:0] illegal_count_o
);
	logic [2:0] ev;
	logic [core_cfg_pkg::CNT_W-1:0] cnt_r [3];

	assign ev = {illegal_i, store_valid_i, wb_valid_i};

	// each counter holds at all ones
	always_ff @(posedge clk_i) begin
		for (int i = 0; i < 3; i++) begin
			if (reset_i) begin
				cnt_r[i] <= '0;
			end else if (ev[i] && !(&cnt_r[i])) begin
				cnt_r[i] <= cnt_r[i] + 1'b1;
			end
		end
	end

	assign alu_count_o = cnt_r[0];
	assign store_count_o = cnt_r[1];
	assign illegal_count_o = cnt_r[2];

endmodule

// File: source/rv_isa_pkg.sv
package rv_isa_pkg;

	// major opcodes handled by the slice
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	// funct3 codes of the OP-IMM group
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;

	// store access size follows funct3[1:0] of SB/SH/SW/SD
	localparam logic [2:0] XRS_RWE_S8 = 3'b000;
	localparam logic [2:0] XRS_RWE_S16 = 3'b001;
	localparam logic [2:0] XRS_RWE_S32 = 3'b010;
	localparam logic [2:0] XRS_RWE_S64 = 3'b011;

	// addi x0, x0, 0
	localparam logic [core_cfg_pkg::INST_W-1:0] INST_NOP = 32'h0000_0013;

	// one instruction word seen as I-type or as S-type
	typedef union packed {
		struct packed {
			logic [11:0] imm;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} i_view;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_view;
	} rv_inst_u;

endpackage

// File: source/store_unit.sv
`timescale 1ns/1ns

module store_unit (
	input  logic clk_i,
	input  logic reset_i,
	input  logic valid_i,
	input  logic [core_cfg_pkg::XLEN-1:0] q_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic wb_i,
	input  logic store_i,
	input  logic [core_cfg_pkg::XLEN-1:0] dat_i,
	input  logic [2:0] xrs_rwe_i,
	input  logic illegal_i,
	output logic wb_valid_o,
	output logic [core_cfg_pkg::REG_ADDR_W-1:0] wb_rd_o,
	output logic [core_cfg_pkg::XLEN-1:0] wb_data_o,
	output logic store_valid_o,
	output logic [core_cfg_pkg::XLEN-1:0] store_addr_o,
	output logic [core_cfg_pkg::XLEN-1:0] store_data_o,
	output logic [core_cfg_pkg::STRB_W-1:0] store_strb_o,
	output logic illegal_o
);
	logic [2:0] lane;
	logic [core_cfg_pkg::STRB_W-1:0] size_mask;
	logic [core_cfg_pkg::XLEN-1:0] q_r;
	logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_r;

	// low address bits pick the starting byte lane
	assign lane = q_i[2:0];

	always_comb begin
		case (xrs_rwe_i)
			rv_isa_pkg::XRS_RWE_S8: size_mask = 8'h01;
			rv_isa_pkg::XRS_RWE_S16: size_mask = 8'h03;
			rv_isa_pkg::XRS_RWE_S32: size_mask = 8'h0f;
			default: size_mask = 8'hff;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_valid_o <= 1'b0;
			store_valid_o <= 1'b0;
			illegal_o <= 1'b0;
		end else begin
			wb_valid_o <= valid_i & wb_i;
			store_valid_o <= valid_i & store_i;
			illegal_o <= valid_i & illegal_i;
		end
		q_r <= q_i;
		rd_r <= rd_i;
		store_data_o <= dat_i << {lane, 3'b000};
		store_strb_o <= size_mask << lane;
	end

	// the sum is the store address or the ALU result
	assign store_addr_o = q_r;
	assign wb_data_o = q_r;
	// also the MEM forwarding tag
	assign wb_rd_o = wb_valid_o ? rd_r : '0;

endmodule

// File: source/xrs_file.sv
`timescale 1ns/1ns

module xrs_file (
	input  logic clk_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs1_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rs2_i,
	input  logic we_i,
	input  logic [core_cfg_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic [core_cfg_pkg::XLEN-1:0] wdata_i,
	output logic [core_cfg_pkg::XLEN-1:0] rs1val_o,
	output logic [core_cfg_pkg::XLEN-1:0] rs2val_o
);
	localparam int NREGS = 1 << core_cfg_pkg::REG_ADDR_W;

	logic [core_cfg_pkg::XLEN-1:0] regs [NREGS];
	logic wr_hit;

	// x0 is never written
	assign wr_hit = we_i && (rd_i != '0);

	always_ff @(posedge clk_i) begin
		if (wr_hit) begin
			regs[rd_i] <= wdata_i;
		end
	end

	// registered reads see a write at the same edge
	always_ff @(posedge clk_i) begin
		if (rs1_i == '0) begin
			rs1val_o <= '0;
		end else if (wr_hit && rd_i == rs1_i) begin
			rs1val_o <= wdata_i;
		end else begin
			rs1val_o <= regs[rs1_i];
		end
		if (rs2_i == '0) begin
			rs2val_o <= '0;
		end else if (wr_hit && rd_i == rs2_i) begin
			rs2val_o <= wdata_i;
		end else begin
			rs2val_o <= regs[rs2_i];
		end
	end

endmodule
